// File: verilog/spinal_pkg.sv
`default_nettype none

package spinal_pkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int WORD_W = 32;
    localparam int HOST_W = 16;
    localparam int TRIG_W = 16;

    // currents, gains, drives and counts all share this word
    typedef logic [WORD_W-1:0] word_t;

    // cortical lanes between sensory input and motor neuron
    localparam int NUM_CN = 2;

    ////////////////////
    // trigger map
    ////////////////////

    // one lane-to-motor gain strobe bit per lane
    localparam int TRIG_GAIN_CN_MN [NUM_CN] = '{3, 9};
    // sensory-to-motor gain
    localparam int TRIG_GAIN_SN_MN = 6;
    // sensory-to-cortex gain shared by every lane
    localparam int TRIG_GAIN_SN_CN = 12;
    // loads every lane drive at once
    localparam int TRIG_DRIVE = 10;

    // reset values
    localparam word_t GAIN_RESET = word_t'(1);
    localparam word_t DRIVE_RESET = word_t'(0);

    ////////////////////
    // neuron and synapse
    ////////////////////

    // current step per presynaptic spike
    localparam word_t SYN_INC = word_t'(1024);
    // current loses cur >> 3 each cycle
    localparam int SYN_DECAY_SHIFT = 3;
    // firing threshold of membrane
    localparam word_t V_TH = word_t'(4096);
    localparam int LEAK_SHIFT = 4;
    // motor spike count window in cycles
    localparam int SPK_WINDOW = 64;

endpackage

`default_nettype wire

// File: verilog/syn_param_if.sv
`timescale 1ns/1ps
`default_nettype none

interface syn_param_if;
    import spinal_pkg::*;

    // shared gain for sensory current into each lane
    word_t gain_sn_cn;
    // per lane gain toward motor neuron
    word_t gain_cn_mn [NUM_CN];
    // sensory gain toward motor neuron
    word_t gain_sn_mn;
    // motor cortex drive, per lane
    word_t m1_drive [NUM_CN];

    // parameter registers own every field
    modport bank (output gain_sn_cn, output gain_cn_mn, output gain_sn_mn, output m1_drive);

    // cortical lane view
    modport lane (input gain_sn_cn, input m1_drive);

    // motor pool view
    modport pool (input gain_sn_mn, input gain_cn_mn);

endinterface

`default_nettype wire

// File: verilog/param_bank.sv
`timescale 1ns/1ps
`default_nettype none

module param_bank (
    input  wire                             ep50trig,
    input  wire                             reset_sim,
    input  wire [spinal_pkg::TRIG_W-1:0]    i_trig,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep01,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep02,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep03,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep04,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep05,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep06,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep07,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep08,
    syn_param_if.bank                       o_params
);
    import spinal_pkg::*;

    // host words by endpoint number
    wire [HOST_W-1:0] ep_word [1:8];
    // gain word, low endpoint in low half
    wire word_t gain_word;

    assign ep_word = '{i_ep01, i_ep02, i_ep03, i_ep04, i_ep05, i_ep06, i_ep07, i_ep08};
    assign gain_word = {ep_word[2], ep_word[1]};

    ////////////////////
    // gains
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_params.gain_sn_mn <= GAIN_RESET;
        else if (i_trig[TRIG_GAIN_SN_MN])
            o_params.gain_sn_mn <= gain_word;
    end

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_params.gain_sn_cn <= GAIN_RESET;
        else if (i_trig[TRIG_GAIN_SN_CN])
            o_params.gain_sn_cn <= gain_word;
    end

    // each lane gain has its own strobe bit
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        for (int k = 0; k < NUM_CN; k++)
        begin
            if (reset_sim)
                o_params.gain_cn_mn[k] <= GAIN_RESET;
            else if (i_trig[TRIG_GAIN_CN_MN[k]])
                o_params.gain_cn_mn[k] <= gain_word;
        end
    end

    ////////////////////
    // drives
    ////////////////////

    // one strobe, lane k takes endpoints 5+2k (low) and 6+2k (high)
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        for (int k = 0; k < NUM_CN; k++)
        begin
            if (reset_sim)
                o_params.m1_drive[k] <= DRIVE_RESET;
            else if (i_trig[TRIG_DRIVE])
                o_params.m1_drive[k] <= {ep_word[6 + 2*k], ep_word[5 + 2*k]};
        end
    end

    // a value seen changed must come from the strobe one edge back
    a_sn_mn_load: assert property (@(posedge ep50trig) disable iff (reset_sim)
        !$stable(o_params.gain_sn_mn) |-> $past(i_trig[TRIG_GAIN_SN_MN]));

    a_sn_cn_load: assert property (@(posedge ep50trig) disable iff (reset_sim)
        !$stable(o_params.gain_sn_cn) |-> $past(i_trig[TRIG_GAIN_SN_CN]));

    for (genvar g = 0; g < NUM_CN; g++)
    begin : g_load_chk
        a_cn_mn_load: assert property (@(posedge ep50trig) disable iff (reset_sim)
            !$stable(o_params.gain_cn_mn[g]) |-> $past(i_trig[TRIG_GAIN_CN_MN[g]]));

        a_drive_load: assert property (@(posedge ep50trig) disable iff (reset_sim)
            !$stable(o_params.m1_drive[g]) |-> $past(i_trig[TRIG_DRIVE]));
    end

endmodule

`default_nettype wire

// File: verilog/synapse_current.sv
`timescale 1ns/1ps
`default_nettype none

module synapse_current (
    input  wire                     ep50trig,
    input  wire                     reset_sim,
    input  wire                     i_spike,
    output spinal_pkg::word_t       o_current
);
    import spinal_pkg::*;

    // decayed current before this cycle's spike
    word_t decayed;
    // spike contribution
    word_t step;

    always_comb
    begin
        decayed = o_current - (o_current >> SYN_DECAY_SHIFT);
        step = i_spike ? SYN_INC : word_t'(0);
    end

    ////////////////////
    // current register
    ////////////////////

    // no saturation, large rates just wrap
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            o_current <= '0;
        else
            o_current <= decayed + step;
    end

endmodule

`default_nettype wire

// File: verilog/lif_neuron.sv
`timescale 1ns/1ps
`default_nettype none

module lif_neuron (
    input  wire                     ep50trig,
    input  wire                     reset_sim,
    input  wire spinal_pkg::word_t  i_drive,
    output logic                    o_spike
);
    import spinal_pkg::*;

    // membrane potential
    word_t v;
    // leaked membrane plus drive
    word_t v_new;

    // leak is v >> LEAK_SHIFT each cycle
    always_comb
    begin
        v_new = v - (v >> LEAK_SHIFT) + i_drive;
    end

    ////////////////////
    // integrate and fire
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            v <= '0;
            o_spike <= 1'b0;
        end
        else if (o_spike)
        begin
            // one-cycle refractory, membrane held at rest
            v <= '0;
            o_spike <= 1'b0;
        end
        else if (v_new >= V_TH)
        begin
            // fire and reset
            v <= '0;
            o_spike <= 1'b1;
        end
        else
        begin
            v <= v_new;
            o_spike <= 1'b0;
        end
    end

    // spikes are always separated by a quiet cycle
    a_no_burst: assert property (@(posedge ep50trig) disable iff (reset_sim)
        o_spike |=> !o_spike);

endmodule

`default_nettype wire

// File: verilog/cortical_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cortical_unit #(
    parameter int LANE = 0
) (
    input  wire                     ep50trig,
    input  wire                     reset_sim,
    input  wire spinal_pkg::word_t  i_sn_current,
    syn_param_if.lane               i_params,
    output wire                     o_spike,
    output wire spinal_pkg::word_t  o_current
);
    import spinal_pkg::*;

    // scaled sensory current, low word of product
    word_t epsc_sn;
    // sensory plus motor cortex drive
    word_t drive_next;
    // latched neuron drive
    word_t drive_q;

    ////////////////////
    // input stage
    ////////////////////

    always_comb
    begin
        epsc_sn = i_sn_current * i_params.gain_sn_cn;
        drive_next = epsc_sn + i_params.m1_drive[LANE];
    end

    // latch one edge behind the sensory current
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            drive_q <= '0;
        else
            drive_q <= drive_next;
    end

    ////////////////////
    // neuron and output synapse
    ////////////////////

    lif_neuron u_neuron (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_drive    (drive_q),
        .o_spike    (o_spike)
    );

    // lane spikes into current toward motor pool
    synapse_current u_out_syn (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_spike    (o_spike),
        .o_current  (o_current)
    );

endmodule

`default_nettype wire

// File: verilog/motor_pool.sv
`timescale 1ns/1ps
`default_nettype none

module motor_pool (
    input  wire                     ep50trig,
    input  wire                     reset_sim,
    input  wire spinal_pkg::word_t  i_sn_current,
    input  wire spinal_pkg::word_t  i_cn_current [spinal_pkg::NUM_CN],
    syn_param_if.pool               i_params,
    output wire                     o_mn_spike,
    output spinal_pkg::word_t       o_mn_spkcnt,
    output wire spinal_pkg::word_t  o_epsc_sn_to_mn
);
    import spinal_pkg::*;

    // summed motor current, before latch
    word_t mn_sum;
    // latched motor drive
    word_t drive_q;
    // cycles into current window
    word_t win_cnt;
    // spikes counted so far in window
    word_t spk_cnt;
    // current spike as a count step
    word_t spk_step;
    // last edge of the window
    logic win_end;

    ////////////////////
    // current sum
    ////////////////////

    // combinational from synapse registers
    assign o_epsc_sn_to_mn = i_sn_current * i_params.gain_sn_mn;

    always_comb
    begin
        mn_sum = o_epsc_sn_to_mn;
        for (int k = 0; k < NUM_CN; k++)
        begin
            mn_sum = mn_sum + i_cn_current[k] * i_params.gain_cn_mn[k];
        end
    end

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            drive_q <= '0;
        else
            drive_q <= mn_sum;
    end

    lif_neuron u_neuron (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_drive    (drive_q),
        .o_spike    (o_mn_spike)
    );

    ////////////////////
    // spike window
    ////////////////////

    assign spk_step = word_t'(o_mn_spike);
    assign win_end = (win_cnt == word_t'(SPK_WINDOW - 1));

    // first copy lands SPK_WINDOW edges after reset release
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            win_cnt <= '0;
            spk_cnt <= '0;
            o_mn_spkcnt <= '0;
        end
        else if (win_end)
        begin
            // include the spike seen on this edge
            win_cnt <= '0;
            spk_cnt <= '0;
            o_mn_spkcnt <= spk_cnt + spk_step;
        end
        else
        begin
            win_cnt <= win_cnt + word_t'(1);
            spk_cnt <= spk_cnt + spk_step;
        end
    end

    // refractory neuron fires at most every other cycle
    a_cnt_bound: assert property (@(posedge ep50trig) disable iff (reset_sim)
        o_mn_spkcnt <= word_t'(SPK_WINDOW / 2));

endmodule

`default_nettype wire

// File: verilog/spinal_loop_top.sv
`timescale 1ns/1ps
`default_nettype none

module spinal_loop_top (
    input  wire                             ep50trig,
    input  wire                             reset_sim,
    input  wire [spinal_pkg::TRIG_W-1:0]    i_trig,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep01,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep02,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep03,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep04,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep05,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep06,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep07,
    input  wire [spinal_pkg::HOST_W-1:0]    i_ep08,
    input  wire                             i_sn_spike,
    output wire [spinal_pkg::NUM_CN-1:0]    o_cn_spike,
    output wire                             o_mn_spike,
    output wire spinal_pkg::word_t          o_mn_spkcnt,
    output wire spinal_pkg::word_t          o_epsc_sn_to_mn
);
    import spinal_pkg::*;

    // sensory synapse current
    wire word_t sn_current;
    // lane output synapse currents
    wire word_t cn_current [NUM_CN];

    syn_param_if u_params ();

    ////////////////////
    // parameters
    ////////////////////

    param_bank u_bank (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_trig     (i_trig),
        .i_ep01     (i_ep01),
        .i_ep02     (i_ep02),
        .i_ep03     (i_ep03),
        .i_ep04     (i_ep04),
        .i_ep05     (i_ep05),
        .i_ep06     (i_ep06),
        .i_ep07     (i_ep07),
        .i_ep08     (i_ep08),
        .o_params   (u_params.bank)
    );

    // sensory spikes into one synapse
    synapse_current u_sn_syn (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_spike    (i_sn_spike),
        .o_current  (sn_current)
    );

    ////////////////////
    // cortical lanes
    ////////////////////

    for (genvar g = 0; g < NUM_CN; g++)
    begin : g_lane
        cortical_unit #(
            .LANE   (g)
        ) u_cn (
            .ep50trig       (ep50trig),
            .reset_sim      (reset_sim),
            .i_sn_current   (sn_current),
            .i_params       (u_params.lane),
            .o_spike        (o_cn_spike[g]),
            .o_current      (cn_current[g])
        );
    end

    // motor neuron and spike counter
    motor_pool u_mn (
        .ep50trig           (ep50trig),
        .reset_sim          (reset_sim),
        .i_sn_current       (sn_current),
        .i_cn_current       (cn_current),
        .i_params           (u_params.pool),
        .o_mn_spike         (o_mn_spike),
        .o_mn_spkcnt        (o_mn_spkcnt),
        .o_epsc_sn_to_mn    (o_epsc_sn_to_mn)
    );

endmodule

`default_nettype wire

// File: sim/tb_spinal_checks.svh
`ifndef TB_SPINAL_CHECKS_SVH
`define TB_SPINAL_CHECKS_SVH

////////////////////
// reset release
////////////////////

// first edge after release, everything still clear
a_reset_clear: assert property (@(posedge ep50trig)
    $fell(reset_sim) |->
        (o_cn_spike == '0 && !o_mn_spike && o_mn_spkcnt == '0 && o_epsc_sn_to_mn == '0))
else
    stop_on_error($sformatf(
        "error: reset_clear expected 0/0/0/0 actual cn %0b mn %0b cnt %0d epsc %0d",
        $sampled(o_cn_spike), $sampled(o_mn_spike),
        $sampled(o_mn_spkcnt), $sampled(o_epsc_sn_to_mn)));

////////////////////
// sensory to motor current
////////////////////

// low word of current times gain, every cycle
a_epsc: assert property (@(posedge ep50trig) disable iff (reset_sim)
    o_epsc_sn_to_mn == word_t'(m_sn_cur * m_gain_sn_mn))
else
    stop_on_error($sformatf("error: epsc_sn_to_mn expected %0d actual %0d",
        word_t'($sampled(m_sn_cur) * $sampled(m_gain_sn_mn)), $sampled(o_epsc_sn_to_mn)));

// no input and no drive, so silence
a_quiet: assert property (@(posedge ep50trig) disable iff (reset_sim)
    (phase == PH_QUIET) |-> (o_cn_spike == '0 && !o_mn_spike))
else
    stop_on_error($sformatf("error: quiet expected cn 0 mn 0 actual cn %0b mn %0b",
        $sampled(o_cn_spike), $sampled(o_mn_spike)));

////////////////////
// lane drive
////////////////////

// lane 1 has no drive
a_lane1_silent: assert property (@(posedge ep50trig) disable iff (reset_sim)
    (phase == PH_DRIVE) |-> !o_cn_spike[1])
else
    stop_on_error("error: lane_drive expected lane 1 spike 0 actual 1");

// judged on the edge where the drive phase ends
a_lane0_fires: assert property (@(posedge ep50trig) disable iff (reset_sim)
    ($past(phase) == PH_DRIVE && phase != PH_DRIVE) |-> lane0_seen)
else
    stop_on_error("lane 0 did not spike once during the drive phase");

// windowed motor spike count
a_spkcnt: assert property (@(posedge ep50trig) disable iff (reset_sim)
    o_mn_spkcnt == exp_spkcnt)
else
    stop_on_error($sformatf("error: spike_window expected %0d actual %0d",
        $sampled(exp_spkcnt), $sampled(o_mn_spkcnt)));

`endif

// File: sim/tb_spinal_loop.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spinal_loop;
    import spinal_pkg::*;

    ////////////////////
    // run length
    ////////////////////

    localparam int CLK_PERIOD = 4;
    localparam int RNG_SEED = 97113;
    localparam int RESET_CYC = 4;
    localparam int QUIET_CYC = 200;
    localparam int EPSC_CYC = 300;
    // lets the sensory current and lane membranes run down
    localparam int SETTLE_CYC = 100;
    localparam int DRIVE_CYC = 200;
    localparam int WINDOW_CYC = 8 * SPK_WINDOW;
    // one cycle per strobe
    localparam int LOAD_CYC = 4;
    localparam int TOTAL_CYC = RESET_CYC + QUIET_CYC + EPSC_CYC + SETTLE_CYC
                             + DRIVE_CYC + WINDOW_CYC + LOAD_CYC + 20;

    // phase codes, seen by the checks
    localparam int PH_RESET = 0;
    localparam int PH_QUIET = 1;
    localparam int PH_EPSC = 2;
    localparam int PH_SETTLE = 3;
    localparam int PH_DRIVE = 4;
    localparam int PH_WINDOW = 5;

    logic ep50trig;
    logic reset_sim;
    logic [TRIG_W-1:0] i_trig;
    logic [HOST_W-1:0] i_ep01;
    logic [HOST_W-1:0] i_ep02;
    logic [HOST_W-1:0] i_ep03;
    logic [HOST_W-1:0] i_ep04;
    logic [HOST_W-1:0] i_ep05;
    logic [HOST_W-1:0] i_ep06;
    logic [HOST_W-1:0] i_ep07;
    logic [HOST_W-1:0] i_ep08;
    logic i_sn_spike;
    wire [NUM_CN-1:0] o_cn_spike;
    wire o_mn_spike;
    wire word_t o_mn_spkcnt;
    wire word_t o_epsc_sn_to_mn;

    int phase;

    // reference model state
    word_t m_sn_cur;
    word_t m_gain_sn_mn;
    word_t exp_spkcnt;
    int unsigned n_edge;
    int unsigned win_spikes;
    logic lane0_seen;

    spinal_loop_top dut0 (
        .ep50trig           (ep50trig),
        .reset_sim          (reset_sim),
        .i_trig             (i_trig),
        .i_ep01             (i_ep01),
        .i_ep02             (i_ep02),
        .i_ep03             (i_ep03),
        .i_ep04             (i_ep04),
        .i_ep05             (i_ep05),
        .i_ep06             (i_ep06),
        .i_ep07             (i_ep07),
        .i_ep08             (i_ep08),
        .i_sn_spike         (i_sn_spike),
        .o_cn_spike         (o_cn_spike),
        .o_mn_spike         (o_mn_spike),
        .o_mn_spkcnt        (o_mn_spkcnt),
        .o_epsc_sn_to_mn    (o_epsc_sn_to_mn)
    );

    always #(CLK_PERIOD / 2) ep50trig = ~ep50trig;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at first failure");
    endtask

    // one strobe bit set
    function automatic logic [TRIG_W-1:0] trig_mask(input int idx);
        logic [TRIG_W-1:0] m;
        m = '0;
        m[idx] = 1'b1;
        return m;
    endfunction

    // single-cycle strobe with gain and drive words on the endpoints
    task automatic strobe(input logic [TRIG_W-1:0] bits, input word_t gain,
                          input word_t drive0, input word_t drive1);
        i_trig = bits;
        {i_ep02, i_ep01} = gain;
        {i_ep06, i_ep05} = drive0;
        {i_ep08, i_ep07} = drive1;
        @(negedge ep50trig);
        i_trig = '0;
    endtask

    // sensory spike high with pct percent chance each cycle
    task automatic run_spikes(input int cycles, input int unsigned pct);
        for (int i = 0; i < cycles; i++)
        begin
            i_sn_spike = ($urandom % 100) < pct;
            @(negedge ep50trig);
        end
        i_sn_spike = 1'b0;
    endtask

    ////////////////////
    // reference models
    ////////////////////

    // gain register and sensory synapse
    always @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            m_sn_cur <= '0;
            m_gain_sn_mn <= word_t'(1);
        end
        else
        begin
            m_sn_cur <= m_sn_cur - (m_sn_cur >> SYN_DECAY_SHIFT)
                        + (i_sn_spike ? word_t'(1024) : word_t'(0));
            if (i_trig[TRIG_GAIN_SN_MN])
                m_gain_sn_mn <= {i_ep02, i_ep01};
        end
    end

    // motor spikes per window, counted by edge number since release
    always @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            n_edge <= 0;
            win_spikes <= 0;
            exp_spkcnt <= '0;
        end
        else
        begin
            n_edge <= n_edge + 1;
            if ((n_edge + 1) % SPK_WINDOW == 0)
            begin
                exp_spkcnt <= word_t'(win_spikes + o_mn_spike);
                win_spikes <= 0;
            end
            else
                win_spikes <= win_spikes + o_mn_spike;
        end
    end

    // any lane 0 spike while the drive phase runs
    always @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            lane0_seen <= 1'b0;
        else if (phase == PH_DRIVE && o_cn_spike[0])
            lane0_seen <= 1'b1;
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial
    begin
        logic [TRIG_W-1:0] gain_bits;

        void'($urandom(RNG_SEED));
        ep50trig = 1'b0;
        reset_sim = 1'b1;
        i_trig = '0;
        i_ep01 = '0;
        i_ep02 = '0;
        i_ep03 = '0;
        i_ep04 = '0;
        i_ep05 = '0;
        i_ep06 = '0;
        i_ep07 = '0;
        i_ep08 = '0;
        i_sn_spike = 1'b0;
        phase = PH_RESET;

        repeat (RESET_CYC) @(negedge ep50trig);
        reset_sim = 1'b0;

        // nothing drives the network
        phase = PH_QUIET;
        run_spikes(QUIET_CYC, 0);

        // random spikes, sensory-to-motor gain swapped halfway
        phase = PH_EPSC;
        run_spikes(EPSC_CYC / 2, 50);
        strobe(trig_mask(TRIG_GAIN_SN_MN), word_t'(32'h0001_2345), '0, '0);
        run_spikes(EPSC_CYC - EPSC_CYC / 2, 50);

        phase = PH_SETTLE;
        run_spikes(SETTLE_CYC, 0);

        // large drive on lane 0 only
        phase = PH_DRIVE;
        strobe(trig_mask(TRIG_DRIVE), '0, word_t'(32'h0000_2000), '0);
        run_spikes(DRIVE_CYC, 0);

        // drives back to 0, every gain raised, heavy input
        phase = PH_WINDOW;
        strobe(trig_mask(TRIG_DRIVE), '0, '0, '0);
        gain_bits = trig_mask(TRIG_GAIN_SN_MN) | trig_mask(TRIG_GAIN_SN_CN);
        for (int k = 0; k < NUM_CN; k++)
        begin
            gain_bits = gain_bits | trig_mask(TRIG_GAIN_CN_MN[k]);
        end
        strobe(gain_bits, word_t'(4), '0, '0);
        run_spikes(WINDOW_CYC, 75);

        $display("Testbench passed");
        $finish;
    end

    // watchdog
    initial
    begin
        #(TOTAL_CYC * CLK_PERIOD);
        stop_on_error($sformatf("timeout: run still going after %0d cycles", TOTAL_CYC));
    end

    `include "tb_spinal_checks.svh"

endmodule

`default_nettype wire

// File: spinal_loop_top.f
+incdir+sim
verilog/spinal_pkg.sv
verilog/syn_param_if.sv
verilog/param_bank.sv
verilog/synapse_current.sv
verilog/lif_neuron.sv
verilog/cortical_unit.sv
verilog/motor_pool.sv
verilog/spinal_loop_top.sv
sim/tb_spinal_loop.sv

// File: Bender.yml
package:
  name: spinal_loop

sources:
  - verilog/spinal_pkg.sv
  - verilog/syn_param_if.sv
  - verilog/param_bank.sv
  - verilog/synapse_current.sv
  - verilog/lif_neuron.sv
  - verilog/cortical_unit.sv
  - verilog/motor_pool.sv
  - verilog/spinal_loop_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_spinal_loop.sv
